// File: sources.f
common/sram_geom_pkg.sv
common/bridge_pkg.sv
common/fifo_rd_if.sv
rtl/credit_counter.sv
src_sram/sram_fifo.sv
src_sram/latency_bridge.sv
src_sram/src_sram_unit.sv
dv/tb_clkgen.sv
dv/src_sram_unit_chk.sv
dv/tb_src_sram_unit.sv

// File: Makefile
# Verilator build and run for the source SRAM buffer

LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_src_sram_unit \
		-f sources.f --Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// File: dv/tb_src_sram_unit.sv
// ====================
// Testbench top for the source SRAM buffer
// Stimulus, credit model, scoreboard, timeout
// ====================

module tb_src_sram_unit;

        timeunit 1ns;
        timeprecision 1ps;

        localparam int DW           = sram_geom_pkg::DATA_WIDTH;
        localparam int CW           = sram_geom_pkg::COUNT_WIDTH;
        localparam int SW           = sram_geom_pkg::SIZE_WIDTH;
        localparam int DEPTH        = sram_geom_pkg::SRAM_DEPTH;
        // Held plus in flight inside the bridge
        localparam int BRIDGE_BEATS = 2;
        localparam int RANDOM_BEATS = 200;
        localparam int STREAM_BEATS = 32;
        // 6 phases of about 300 cycles, doubled, plus slack
        localparam int TIMEOUT_CYCLES = 4000;
        localparam int DRIVE_DELAY    = 10;
        localparam logic [31:0] SEED  = 32'h85fa;

        logic          clk;
        logic          rst_n;
        logic          fill_alloc_req;
        logic [SW-1:0] fill_alloc_size;
        logic [CW-1:0] fill_space_free;
        logic          fill_valid;
        logic          fill_ready;
        logic [DW-1:0] fill_data;
        logic [CW-1:0] drain_data_avail;
        logic          drain_req;
        logic [SW-1:0] drain_size;
        logic          drain_valid;
        logic          drain_ready;
        logic [DW-1:0] drain_data;

        // Accepted beats, oldest first
        logic [DW-1:0] sb_q [$];
        int            stream_edges [$];
        int            stream_first_fill = -1;
        bit            stream_mode = 1'b0;
        int            errors = 0;
        int            cyc = 0;
        int            sent_cnt = 0;
        int            recv_cnt = 0;
        // Counter values after the last edge, and the space report
        int            exp_data = 0;
        int            exp_space = DEPTH;
        int            exp_free = DEPTH;
        string         test_name = "reset";

        tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

        src_sram_unit src_sram_unit_inst (.*);

        bind latency_bridge src_sram_unit_chk u_bridge_chk (
                .clk (clk), .rst_n (rst_n), .rd_en (rd.rd_en),
                .rd_data_valid (rd.rd_data_valid), .pending (pending), .state (state),
                .m_valid (m_valid), .m_ready (m_ready), .m_data (m_data)
        );

        // Plus one per beat, minus size per pulse, wraps at count width
        function automatic int model_credits(input int count, input bit inc,
                                             input bit dec, input int size);
                int result;
                result = count + (inc ? 1 : 0) - (dec ? size : 0);
                return result & ((1 << CW) - 1);
        endfunction

        task automatic check_value(input string name, input longint exp, input longint got);
                assert (exp == got) else begin
                        errors++;
                        $display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
                end
        endtask

        task automatic finish_run();
                $display("Run done: %0d errors, %0d beats in, %0d beats out",
                         errors, sent_cnt, recv_cnt);
                if (errors == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        endtask

        // ====================
        // Cycle count and timeout
        // ====================

        always @(posedge clk) begin
                cyc <= cyc + 1;
                if (cyc >= TIMEOUT_CYCLES) begin
                        errors++;
                        $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                        finish_run();
                end
        end

        // ====================
        // Compare at mid-cycle
        // ====================

        // Handshakes seen here land on the next rising edge
        always @(negedge clk) begin : compare
                bit fill_fire;
                bit drain_fire;
                if (rst_n) begin
                        fill_fire  = fill_valid && fill_ready;
                        drain_fire = drain_valid && drain_ready;
                        check_value({test_name, " drain_data_avail"}, exp_data, drain_data_avail);
                        check_value({test_name, " fill_space_free"}, exp_free, fill_space_free);
                        if (drain_fire) begin
                                assert (sb_q.size() != 0) else begin
                                        errors++;
                                        $display("ERROR %s: beat drained with none outstanding",
                                                 test_name);
                                end
                                if (sb_q.size() != 0) begin
                                        check_value({test_name, " drain_data"}, sb_q.pop_front(),
                                                    drain_data);
                                end
                                recv_cnt++;
                                if (stream_mode) stream_edges.push_back(cyc + 1);
                        end
                        if (fill_fire) begin
                                sb_q.push_back(fill_data);
                                sent_cnt++;
                                if (stream_mode && stream_first_fill < 0) begin
                                        stream_first_fill = cyc + 1;
                                end
                        end
                        // Space report trails the counter by one register
                        exp_free  = exp_space;
                        exp_space = model_credits(exp_space, drain_fire, fill_alloc_req,
                                                  int'(fill_alloc_size));
                        exp_data  = model_credits(exp_data, fill_fire, drain_req, int'(drain_size));
                end
        end

        // ====================
        // Stimulus
        // ====================

        // Pulses last one cycle
        task automatic next_cycle();
                @(posedge clk);
                #DRIVE_DELAY;
                fill_alloc_req = 1'b0;
                drain_req      = 1'b0;
        endtask

        task automatic drain_all();
                fill_valid  = 1'b0;
                drain_ready = 1'b1;
                while (sb_q.size() != 0) next_cycle();
                // Last beat still transfers on the coming edge
                repeat (4) next_cycle();
        endtask

        task automatic run_random();
                int target;
                target = sent_cnt + RANDOM_BEATS;
                while (recv_cnt < target) begin
                        fill_valid  = (sent_cnt < target) && ($urandom % 2 == 1);
                        fill_data   = $urandom;
                        drain_ready = 1'($urandom % 2);
                        if ($urandom % 4 == 0 && exp_space >= 4) begin
                                fill_alloc_req  = 1'b1;
                                fill_alloc_size = SW'(1 + $urandom % 3);
                        end
                        if ($urandom % 4 == 0 && exp_data >= 4) begin
                                drain_req  = 1'b1;
                                drain_size = SW'(1 + $urandom % 3);
                        end
                        next_cycle();
                end
                fill_valid = 1'b0;
        endtask

        task automatic run_credit_pairs();
                // Park beats so a drain handshake is ready
                drain_ready = 1'b0;
                fill_valid  = 1'b1;
                repeat (4) begin
                        fill_data = $urandom;
                        next_cycle();
                end
                fill_valid = 1'b0;
                repeat (3) next_cycle();
                // Both counters take an add and a subtract on one edge
                fill_valid      = 1'b1;
                fill_data       = $urandom;
                drain_ready     = 1'b1;
                fill_alloc_req  = 1'b1;
                fill_alloc_size = SW'(3);
                drain_req       = 1'b1;
                drain_size      = SW'(2);
                next_cycle();
                fill_valid  = 1'b0;
                drain_ready = 1'b0;
                // Lone events
                fill_alloc_req  = 1'b1;
                fill_alloc_size = SW'(2);
                next_cycle();
                drain_req  = 1'b1;
                drain_size = SW'(1);
                repeat (4) next_cycle();
        endtask

        task automatic run_full();
                int start;
                start       = sent_cnt;
                drain_ready = 1'b0;
                fill_valid  = 1'b1;
                do begin
                        fill_data = $urandom;
                        next_cycle();
                end while (fill_ready);
                // Nothing more gets in while stalled
                repeat (4) next_cycle();
                fill_valid = 1'b0;
                check_value("full accepted_beats", DEPTH + BRIDGE_BEATS, sent_cnt - start);
                check_value("full drain_valid", 1, drain_valid);
        endtask

        task automatic run_stream();
                int start;
                stream_edges.delete();
                stream_first_fill = -1;
                stream_mode       = 1'b1;
                start             = sent_cnt;
                drain_ready       = 1'b1;
                while (sent_cnt < start + STREAM_BEATS) begin
                        fill_valid = 1'b1;
                        fill_data  = $urandom;
                        next_cycle();
                end
                drain_all();
                stream_mode = 1'b0;
                check_value("stream beat_count", STREAM_BEATS, stream_edges.size());
                // First beat leaves two edges after its fill, then one per edge
                foreach (stream_edges[i]) begin
                        check_value($sformatf("stream drain_edge %0d", i),
                                    stream_first_fill + 2 + i, stream_edges[i]);
                end
        endtask

        initial begin
                void'($urandom(SEED));
                fill_alloc_req  = 1'b0;
                fill_alloc_size = '0;
                fill_valid      = 1'b0;
                fill_data       = '0;
                drain_req       = 1'b0;
                drain_size      = '0;
                drain_ready     = 1'b0;
                wait (rst_n === 1'b1);
                @(negedge clk);
                check_value("reset drain_valid", 0, drain_valid);
                check_value("reset fill_ready", 1, fill_ready);
                check_value("reset fill_space_free", DEPTH, fill_space_free);
                check_value("reset drain_data_avail", 0, drain_data_avail);
                next_cycle();
                test_name = "random";
                run_random();
                drain_all();
                test_name = "credits";
                run_credit_pairs();
                drain_all();
                test_name = "full";
                run_full();
                drain_all();
                test_name = "stream";
                run_stream();
                // Each accepted beat left exactly once
                check_value("end beats_out", sent_cnt, recv_cnt);
                finish_run();
        end

endmodule : tb_src_sram_unit

// File: dv/src_sram_unit_chk.sv
// ====================
// Concurrent assertions on the latency bridge
// FIFO read rule, output stability, store limit
// ====================

module src_sram_unit_chk (
        input logic                                 clk,
        input logic                                 rst_n,
        input logic                                 rd_en,
        input logic                                 rd_data_valid,
        input logic                                 pending,
        input bridge_pkg::bridge_state_t            state,
        input logic                                 m_valid,
        input logic                                 m_ready,
        input logic [sram_geom_pkg::DATA_WIDTH-1:0] m_data
);

        timeunit 1ns;
        timeprecision 1ps;

        // Every read returns its beat one cycle later
        read_returns_data: assert property (
                @(posedge clk) disable iff (!rst_n)
                rd_en |=> rd_data_valid
        ) else $error("FIFO read returned no data on the next cycle");

        // A waiting beat keeps its data
        data_held_while_stalled: assert property (
                @(posedge clk) disable iff (!rst_n)
                (m_valid && !m_ready) |=> (m_valid && $stable(m_data))
        ) else $error("drain beat changed or dropped while stalled");

        // Full store leaves no room for a beat in flight
        no_read_when_full: assert property (
                @(posedge clk) disable iff (!rst_n)
                (state == bridge_pkg::BR_TWO) |-> !pending
        ) else $error("bridge read in flight with both slots held");

endmodule : src_sram_unit_chk

// File: dv/tb_clkgen.sv
// ====================
// Testbench clock and reset generator
// ====================

module tb_clkgen (
        output logic clk,
        output logic rst_n
);

        timeunit 1ns;
        timeprecision 1ps;

        localparam int PERIOD       = 100;
        localparam int RESET_CYCLES = 8;

        initial begin
                clk = 1'b0;
                forever #(PERIOD / 2) clk = ~clk;
        end

        // Release away from the rising edge
        initial begin
                rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                #(PERIOD / 5);
                rst_n = 1'b1;
        end

endmodule : tb_clkgen

// File: src_sram/src_sram_unit.sv
// ====================
// Source-path SRAM buffer top level
// Credit counters, FIFO, latency bridge
// ====================

module src_sram_unit (
        input  logic                                  clk,
        input  logic                                  rst_n,

        // Space allocation from the read engine
        input  logic                                  fill_alloc_req,
        input  logic [sram_geom_pkg::SIZE_WIDTH-1:0]  fill_alloc_size,
        output logic [sram_geom_pkg::COUNT_WIDTH-1:0] fill_space_free,

        // Fill data stream
        input  logic                                  fill_valid,
        output logic                                  fill_ready,
        input  logic [sram_geom_pkg::DATA_WIDTH-1:0]  fill_data,

        // Data credits to the network master
        output logic [sram_geom_pkg::COUNT_WIDTH-1:0] drain_data_avail,
        input  logic                                  drain_req,
        input  logic [sram_geom_pkg::SIZE_WIDTH-1:0]  drain_size,

        // Drain data stream
        output logic                                  drain_valid,
        input  logic                                  drain_ready,
        output logic [sram_geom_pkg::DATA_WIDTH-1:0]  drain_data
);

        // ====================
        // Internal signals
        // ====================

        logic [sram_geom_pkg::COUNT_WIDTH-1:0] space_count;
        logic                                  fill_fire;
        logic                                  drain_fire;

        fifo_rd_if u_rd_if ();

        assign fill_fire  = fill_valid && fill_ready;
        assign drain_fire = drain_valid && drain_ready;

        // ====================
        // Credit counters
        // ====================

        // Space freed as each beat leaves the unit
        credit_counter #(
                .INIT_VALUE (sram_geom_pkg::SRAM_DEPTH)
        ) u_space_cnt (
                .clk      (clk),
                .rst_n    (rst_n),
                .inc      (drain_fire),
                .dec      (fill_alloc_req),
                .dec_size (fill_alloc_size),
                .count    (space_count)
        );

        // Data made available as each beat is written
        credit_counter #(
                .INIT_VALUE (0)
        ) u_data_cnt (
                .clk      (clk),
                .rst_n    (rst_n),
                .inc      (fill_fire),
                .dec      (drain_req),
                .dec_size (drain_size),
                .count    (drain_data_avail)
        );

        // ====================
        // Data path
        // ====================

        sram_fifo u_fifo (
                .clk      (clk),
                .rst_n    (rst_n),
                .wr_valid (fill_valid),
                .wr_ready (fill_ready),
                .wr_data  (fill_data),
                .rd       (u_rd_if.fifo_side)
        );

        latency_bridge u_bridge (
                .clk     (clk),
                .rst_n   (rst_n),
                .rd      (u_rd_if.bridge_side),
                .m_valid (drain_valid),
                .m_data  (drain_data),
                .m_ready (drain_ready)
        );

        // Extra stage on the space report
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        fill_space_free <= sram_geom_pkg::COUNT_WIDTH'(sram_geom_pkg::SRAM_DEPTH);
                end else begin
                        fill_space_free <= space_count;
                end
        end

endmodule : src_sram_unit

// File: src_sram/latency_bridge.sv
// ====================
// Latency bridge over the FIFO read port
// Two-entry skid store, valid/ready output
// ====================

module latency_bridge (
        input  logic                                 clk,
        input  logic                                 rst_n,

        // FIFO read port
        fifo_rd_if.bridge_side                       rd,

        // Drain stream
        output logic                                 m_valid,
        output logic [sram_geom_pkg::DATA_WIDTH-1:0] m_data,
        input  logic                                 m_ready
);

        // ====================
        // State
        // ====================

        bridge_pkg::bridge_state_t              state;
        bridge_pkg::bridge_state_t              state_next;

        // Read issued last cycle, data arriving now
        logic                                   pending;

        // Skid slots, slot0 is the oldest
        logic [sram_geom_pkg::DATA_WIDTH-1:0]   slot0;
        logic [sram_geom_pkg::DATA_WIDTH-1:0]   slot1;

        logic [bridge_pkg::OCC_WIDTH-1:0]       held;
        logic [bridge_pkg::OCC_WIDTH-1:0]       committed;
        logic                                   pop;

        // ====================
        // Read issue
        // ====================

        // State encoding equals beats held
        assign held      = state;
        assign committed = held + bridge_pkg::OCC_WIDTH'(pending);

        // Never more than two beats held plus in flight
        assign rd.rd_en = rd.not_empty && (committed < bridge_pkg::OCC_WIDTH'(2));

        // ====================
        // Output
        // ====================

        // Empty store passes returned data straight through
        assign m_valid = (state != bridge_pkg::BR_EMPTY) || rd.rd_data_valid;
        assign m_data  = (state != bridge_pkg::BR_EMPTY) ? slot0 : rd.rd_data;
        assign pop     = m_valid && m_ready;

        // ====================
        // Next state
        // ====================

        always_comb begin
                state_next = state;
                case (state)
                        // Stall on arrival parks the beat
                        bridge_pkg::BR_EMPTY: begin
                                if (rd.rd_data_valid && !m_ready) begin
                                        state_next = bridge_pkg::BR_ONE;
                                end
                        end
                        bridge_pkg::BR_ONE: begin
                                if (pop && !rd.rd_data_valid) begin
                                        state_next = bridge_pkg::BR_EMPTY;
                                end else if (!pop && rd.rd_data_valid) begin
                                        state_next = bridge_pkg::BR_TWO;
                                end
                        end
                        // Issue rule keeps arrivals out of a full store
                        bridge_pkg::BR_TWO: begin
                                if (pop && !rd.rd_data_valid) begin
                                        state_next = bridge_pkg::BR_ONE;
                                end
                        end
                        default: state_next = bridge_pkg::BR_EMPTY;
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state   <= bridge_pkg::BR_EMPTY;
                        pending <= 1'b0;
                end else begin
                        state   <= state_next;
                        pending <= rd.rd_en;
                end
        end

        // ====================
        // Skid slots
        // ====================

        // Returned data fills the next free slot
        always_ff @(posedge clk) begin
                case (state)
                        bridge_pkg::BR_EMPTY: begin
                                if (rd.rd_data_valid) begin
                                        slot0 <= rd.rd_data;
                                end
                        end
                        bridge_pkg::BR_ONE: begin
                                if (pop && rd.rd_data_valid) begin
                                        slot0 <= rd.rd_data;
                                end else if (rd.rd_data_valid) begin
                                        slot1 <= rd.rd_data;
                                end
                        end
                        bridge_pkg::BR_TWO: begin
                                // Shift up on a pop
                                if (pop) begin
                                        slot0 <= slot1;
                                        if (rd.rd_data_valid) begin
                                                slot1 <= rd.rd_data;
                                        end
                                end
                        end
                        default: ;
                endcase
        end

endmodule : latency_bridge

// File: src_sram/sram_fifo.sv
// ====================
// Register-array FIFO, one-cycle registered read
// Full flag drives the write ready
// ====================

module sram_fifo (
        input  logic                                 clk,
        input  logic                                 rst_n,

        // Write port from the read engine
        input  logic                                 wr_valid,
        output logic                                 wr_ready,
        input  logic [sram_geom_pkg::DATA_WIDTH-1:0] wr_data,

        // Read port toward the bridge
        fifo_rd_if.fifo_side                         rd
);

        // ====================
        // Storage and pointers
        // ====================

        logic [sram_geom_pkg::DATA_WIDTH-1:0]  mem [sram_geom_pkg::SRAM_DEPTH];

        // Pointers wrap at the power-of-two depth
        logic [sram_geom_pkg::ADDR_WIDTH-1:0]  wr_ptr;
        logic [sram_geom_pkg::ADDR_WIDTH-1:0]  rd_ptr;

        // Stored beats, 0 to SRAM_DEPTH
        logic [sram_geom_pkg::COUNT_WIDTH-1:0] count;

        logic                                  wr_fire;
        logic                                  rd_fire;

        // ====================
        // Status
        // ====================

        // Room while below depth
        assign wr_ready     = (count < sram_geom_pkg::COUNT_WIDTH'(sram_geom_pkg::SRAM_DEPTH));
        assign rd.not_empty = (count != '0);

        assign wr_fire = wr_valid && wr_ready;
        // Bridge only asks while not empty
        assign rd_fire = rd.rd_en && rd.not_empty;

        // ====================
        // Pointers and occupancy
        // ====================

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (wr_fire) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (rd_fire) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        // Simultaneous push and pop leave count alone
                        case ({wr_fire, rd_fire})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        // ====================
        // Array write and read
        // ====================

        always_ff @(posedge clk) begin
                if (wr_fire) begin
                        mem[wr_ptr] <= wr_data;
                end
        end

        // Output register, as a synchronous SRAM
        always_ff @(posedge clk) begin
                if (rd_fire) begin
                        rd.rd_data <= mem[rd_ptr];
                end
        end

        // Valid strobe, high for one cycle per read
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        rd.rd_data_valid <= 1'b0;
                end else begin
                        rd.rd_data_valid <= rd_fire;
                end
        end

endmodule : sram_fifo

// File: rtl/credit_counter.sv
// ====================
// Up/down beat credit counter
// Plus one and minus size in the same cycle
// ====================

module credit_counter #(
        parameter int INIT_VALUE = 0
) (
        input  logic                                  clk,
        input  logic                                  rst_n,

        // Single-beat credit return
        input  logic                                  inc,

        // Bulk credit consumption
        input  logic                                  dec,
        input  logic [sram_geom_pkg::SIZE_WIDTH-1:0]  dec_size,

        output logic [sram_geom_pkg::COUNT_WIDTH-1:0] count
);

        // ====================
        // Next count
        // ====================

        // Sum is formed at request-size width
        logic [sram_geom_pkg::SIZE_WIDTH-1:0] sum_wide;
        logic [sram_geom_pkg::SIZE_WIDTH-1:0] dec_amount;

        // Size only counts on a pulse
        assign dec_amount = dec ? dec_size : '0;

        // Both events land on the same edge
        assign sum_wide = sram_geom_pkg::SIZE_WIDTH'(count)
                        + sram_geom_pkg::SIZE_WIDTH'(inc)
                        - dec_amount;

        // ====================
        // Count register
        // ====================

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        // Space side starts full, data side starts empty
                        count <= sram_geom_pkg::COUNT_WIDTH'(INIT_VALUE);
                end else begin
                        // Low bits hold the credit count
                        count <= sum_wide[sram_geom_pkg::COUNT_WIDTH-1:0];
                end
        end

endmodule : credit_counter

// File: common/fifo_rd_if.sv
// ====================
// FIFO read port between buffer and bridge
// ====================

interface fifo_rd_if;

        // FIFO holds at least one beat
        logic                                 not_empty;
        // Read request, legal only with not_empty
        logic                                 rd_en;
        // Registered read data, one cycle after rd_en
        logic [sram_geom_pkg::DATA_WIDTH-1:0] rd_data;
        logic                                 rd_data_valid;

        // Storage side
        modport fifo_side (
                input  rd_en,
                output not_empty, rd_data, rd_data_valid
        );

        // Consumer side
        modport bridge_side (
                input  not_empty, rd_data, rd_data_valid,
                output rd_en
        );

endinterface : fifo_rd_if

// File: common/bridge_pkg.sv
// ====================
// Latency bridge state type
// Occupancy width of the skid store
// ====================

package bridge_pkg;

        // Beats held in the two-entry skid store
        typedef enum logic [1:0] {
                BR_EMPTY = 2'd0,
                BR_ONE   = 2'd1,
                BR_TWO   = 2'd2
        } bridge_state_t;

        // Held beats plus one read in flight
        // Max sum of 3 still fits
        localparam int OCC_WIDTH = 2;

endpackage : bridge_pkg

// File: common/sram_geom_pkg.sv
// ====================
// Buffer geometry for the source SRAM path
// Data, depth, pointer, count and size widths
// ====================

package sram_geom_pkg;

        // ====================
        // Data path
        // ====================

        // One beat on the fill and drain streams
        localparam int DATA_WIDTH = 32;

        // ====================
        // Storage
        // ====================

        // FIFO entries, a power of two so pointers wrap
        localparam int SRAM_DEPTH = 16;
        localparam int ADDR_WIDTH = $clog2(SRAM_DEPTH);

        // Counts span 0 to SRAM_DEPTH inclusive
        localparam int COUNT_WIDTH = ADDR_WIDTH + 1;

        // Request size on alloc and drain pulses
        localparam int SIZE_WIDTH = 8;

endpackage : sram_geom_pkg
